//--- Bender.yml
package:
  name: cpu8008

sources:
  - common/cpu8008_pkg.sv
  - logic/alu.sv
  - logic/reg_file.sv
  - logic/program_counter.sv
  - control/cycle_sequencer.sv
  - control/instr_decoder.sv
  - logic/cpu8008_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cpu8008_tb.sv

//--- common/cpu8008_pkg.sv
`default_nettype none

package cpu8008_pkg;

  // bus byte and program counter widths
  parameter int data_width = 8;
  parameter int pc_width = 14;

  // T-states of one machine cycle
  typedef enum logic [2:0] {
    T1, T2, T3, T4, T5, WAIT, STOPPED
  } state_t;

  typedef enum logic [1:0] {
    CYCLE1, CYCLE2, CYCLE3
  } cycle_t;

  // sent in bits 7:6 of the T2 byte
  // PCC equals the class bits of the OUT opcode sent in T2
  typedef enum logic [1:0] {
    PCI = 2'b00,
    PCR = 2'b10,
    PCC = 2'b01
  } cycle_type_t;

  // first eight follow the instruction's operation field
  typedef enum logic [3:0] {
    OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_AND, OP_XOR, OP_OR, OP_CMP,
    OP_INC, OP_DEC
  } alu_op_t;

  // internal bus sources
  typedef enum logic [2:0] {
    SRC_INPUT, SRC_REG, SRC_ALU, SRC_PC_LOW, SRC_PC_HIGH, SRC_TMP_B, SRC_ACC, SRC_IR
  } bus_src_t;

  typedef logic [2:0] reg_idx_t;

  // register numbering as on the 8008 with index 7 for memory
  localparam reg_idx_t REG_A = 3'd0;
  localparam reg_idx_t REG_B = 3'd1;
  localparam reg_idx_t REG_C = 3'd2;
  localparam reg_idx_t REG_D = 3'd3;
  localparam reg_idx_t REG_E = 3'd4;
  localparam reg_idx_t REG_H = 3'd5;
  localparam reg_idx_t REG_L = 3'd6;

  // opcode classes in bits 7:6
  localparam logic [1:0] CLS_IMM = 2'b00;
  localparam logic [1:0] CLS_CTRL = 2'b01;
  localparam logic [1:0] CLS_ALU = 2'b10;
  localparam logic [1:0] CLS_MOVE = 2'b11;

  // low field patterns in bits 2:0
  localparam logic [2:0] LOW_INR = 3'b000;
  localparam logic [2:0] LOW_DCR = 3'b001;
  localparam logic [2:0] LOW_ALU_IMM = 3'b100;
  localparam logic [2:0] LOW_LRI = 3'b110;
  localparam logic [2:0] LOW_JMP = 3'b100;

  // the three halt encodings
  localparam logic [7:0] HLT_00 = 8'h00;
  localparam logic [7:0] HLT_01 = 8'h01;
  localparam logic [7:0] HLT_FF = 8'hFF;

  // move view with class, destination and source
  typedef struct packed {
    logic [1:0] cls;
    logic [2:0] ddd;
    logic [2:0] sss;
  } move_view_t;

  // alu view with class, operation and low field
  typedef struct packed {
    logic [1:0] cls;
    logic [2:0] op;
    logic [2:0] low;
  } alu_view_t;

  typedef union packed {
    move_view_t mov;
    alu_view_t alu;
  } instr_u;

endpackage

`default_nettype wire

//--- control/cycle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  ready,
  input  logic                  ends_at_t3,
  input  logic                  last_cycle,
  input  logic                  halt,
  output cpu8008_pkg::state_t   state,
  output cpu8008_pkg::cycle_t   cycle
);
  import cpu8008_pkg::*;

  state_t next_state;
  cycle_t next_cycle;

  always_comb begin
    next_state = state;
    next_cycle = cycle;
    case (state)
      T1: begin
        next_state = T2;
      end
      // memory not ready, stretch in WAIT
      T2, WAIT: begin
        if (ready) begin
          next_state = T3;
        end else begin
          next_state = WAIT;
        end
      end
      T3: begin
        if (halt) begin
          next_state = STOPPED;
        end else if (ends_at_t3) begin
          next_state = T1;
          if (last_cycle) begin
            next_cycle = CYCLE1;
          end else begin
            next_cycle = cycle_t'(cycle + 2'd1);
          end
        end else begin
          next_state = T4;
        end
      end
      T4: begin
        next_state = T5;
      end
      // T5 always closes the instruction
      T5: begin
        next_state = T1;
        next_cycle = CYCLE1;
      end
      // only reset leaves STOPPED
      STOPPED: begin
        next_state = STOPPED;
      end
      default: begin
        next_state = T1;
        next_cycle = CYCLE1;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= T1;
      cycle <= CYCLE1;
    end else begin
      state <= next_state;
      cycle <= next_cycle;
    end
  end

  // decoder never asks for a fourth machine cycle
  no_cycle_past_three: assert property (
    @(posedge clock) disable iff (rst)
      (state == T3 && ends_at_t3 && !last_cycle && !halt) |-> (cycle != CYCLE3)
  );

endmodule

`default_nettype wire

//--- control/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  cpu8008_pkg::instr_u       instr,
  input  cpu8008_pkg::state_t       state,
  input  cpu8008_pkg::cycle_t       cycle,
  output logic                      ends_at_t3,
  output logic                      last_cycle,
  output logic                      halt,
  output cpu8008_pkg::bus_src_t     bus_src,
  output cpu8008_pkg::reg_idx_t     reg_sel,
  output logic                      reg_we,
  output logic                      load_ir,
  output logic                      load_tmp_a,
  output logic                      load_tmp_b,
  output logic                      load_out,
  output logic                      pc_inc,
  output logic                      pc_load_low,
  output logic                      pc_load_high,
  output cpu8008_pkg::cycle_type_t  cycle_type,
  output cpu8008_pkg::alu_op_t      alu_op,
  output logic                      carry_we
);
  import cpu8008_pkg::*;

  logic is_hlt;
  logic is_move;
  logic is_alu_reg;
  logic is_alu_imm;
  logic is_lri;
  logic is_inr;
  logic is_dcr;
  logic is_jmp;
  logic is_out;
  // second cycle of OUT, the PCC cycle
  logic out_cycle;

  // halt first, its encodings overlap INr, DCr and move
  assign is_hlt = (instr == HLT_00) || (instr == HLT_01) || (instr == HLT_FF);
  assign is_move = !is_hlt && instr.alu.cls == CLS_MOVE;
  assign is_alu_reg = instr.alu.cls == CLS_ALU;
  assign is_alu_imm = instr.alu.cls == CLS_IMM && instr.alu.low == LOW_ALU_IMM;
  assign is_lri = instr.alu.cls == CLS_IMM && instr.alu.low == LOW_LRI;
  assign is_inr = !is_hlt && instr.alu.cls == CLS_IMM && instr.alu.low == LOW_INR;
  assign is_dcr = !is_hlt && instr.alu.cls == CLS_IMM && instr.alu.low == LOW_DCR;
  assign is_jmp = instr.alu.cls == CLS_CTRL && instr.alu.low == LOW_JMP;
  // bit 0 set, bits 5:4 nonzero, else it would be INP
  assign is_out = instr.alu.cls == CLS_CTRL && instr.alu.low[0] && instr.alu.op[2:1] != 2'b00;
  assign out_cycle = is_out && cycle == CYCLE2;

  always_comb begin
    ends_at_t3 = 1'b0;
    last_cycle = 1'b0;
    halt = 1'b0;
    bus_src = SRC_INPUT;
    reg_sel = REG_A;
    reg_we = 1'b0;
    load_ir = 1'b0;
    load_tmp_a = 1'b0;
    load_tmp_b = 1'b0;
    load_out = 1'b0;
    pc_inc = 1'b0;
    pc_load_low = 1'b0;
    pc_load_high = 1'b0;
    alu_op = OP_ADD;
    carry_we = 1'b0;
    case (state)
      // low address byte, or A for OUT
      T1: begin
        load_out = 1'b1;
        if (out_cycle) begin
          bus_src = SRC_ACC;
        end else begin
          bus_src = SRC_PC_LOW;
          pc_inc = 1'b1;
        end
      end
      // cycle type and high address, or the OUT opcode
      T2: begin
        load_out = 1'b1;
        if (out_cycle) begin
          bus_src = SRC_IR;
        end else begin
          bus_src = SRC_PC_HIGH;
        end
      end
      // bus defaults to data_in here
      T3: begin
        case (cycle)
          CYCLE1: begin
            load_ir = 1'b1;
            halt = is_hlt;
            ends_at_t3 = is_lri || is_alu_imm || is_out || is_jmp;
          end
          // operand byte or jump low byte
          CYCLE2: begin
            load_tmp_b = !is_out;
            ends_at_t3 = is_out || is_jmp;
            last_cycle = is_out;
          end
          // jump high byte
          default: begin
            load_tmp_a = 1'b1;
          end
        endcase
      end
      T4: begin
        bus_src = SRC_REG;
        load_tmp_b = is_move || is_alu_reg || is_inr || is_dcr;
        if (is_inr || is_dcr) begin
          reg_sel = instr.mov.ddd;
        end else begin
          reg_sel = instr.mov.sss;
        end
        pc_load_high = is_jmp;
      end
      T5: begin
        if (is_move || is_lri) begin
          bus_src = SRC_TMP_B;
          reg_sel = instr.mov.ddd;
          reg_we = 1'b1;
        end else if (is_inr || is_dcr) begin
          bus_src = SRC_ALU;
          alu_op = is_inr ? OP_INC : OP_DEC;
          reg_sel = instr.mov.ddd;
          reg_we = 1'b1;
        end else if (is_alu_reg || is_alu_imm) begin
          bus_src = SRC_ALU;
          alu_op = alu_op_t'({1'b0, instr.alu.op});
          reg_sel = REG_A;
          // compare only sets carry
          reg_we = alu_op != OP_CMP;
          carry_we = 1'b1;
        end else begin
          pc_load_low = is_jmp;
        end
      end
      default: begin
        halt = 1'b0;
      end
    endcase
  end

  always_comb begin
    if (cycle == CYCLE1) begin
      cycle_type = PCI;
    end else if (out_cycle) begin
      cycle_type = PCC;
    end else begin
      cycle_type = PCR;
    end
  end

endmodule

`default_nettype wire

//--- cpu8008.f
+incdir+tests
common/cpu8008_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/program_counter.sv
control/cycle_sequencer.sv
control/instr_decoder.sv
logic/cpu8008_core.sv
tests/cpu8008_tb.sv

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
  parameter int data_width = cpu8008_pkg::data_width
) (
  input  logic                      clock,
  input  logic                      rst,
  input  logic [data_width-1:0]     acc,
  input  logic [data_width-1:0]     operand,
  input  cpu8008_pkg::alu_op_t      op,
  input  logic                      carry_we,
  output logic [data_width-1:0]     result
);
  import cpu8008_pkg::*;

  localparam logic [data_width:0] one = 1;

  logic carry;
  // one bit wider than the byte, top bit is carry or borrow
  logic [data_width:0] wide;
  logic [data_width:0] carry_in;
  logic [data_width:0] acc_ext;
  logic [data_width:0] opd_ext;

  assign carry_in = {{data_width{1'b0}}, carry};
  assign acc_ext = {1'b0, acc};
  assign opd_ext = {1'b0, operand};

  always_comb begin
    case (op)
      OP_ADD: wide = acc_ext + opd_ext;
      OP_ADC: wide = acc_ext + opd_ext + carry_in;
      // borrow lands in the top bit
      OP_SUB, OP_CMP: wide = acc_ext - opd_ext;
      OP_SBB: wide = acc_ext - opd_ext - carry_in;
      // logic ops leave top bit clear so carry clears
      OP_AND: wide = {1'b0, acc & operand};
      OP_XOR: wide = {1'b0, acc ^ operand};
      OP_OR: wide = {1'b0, acc | operand};
      // INr/DCr work on the operand, wrap at FF and 00
      OP_INC: wide = opd_ext + one;
      OP_DEC: wide = opd_ext - one;
      default: wide = acc_ext;
    endcase
  end

  assign result = wide[data_width-1:0];

  // carry flag, written on the edge that ends T5
  always_ff @(posedge clock) begin
    if (rst) begin
      carry <= 1'b0;
    end else if (carry_we) begin
      carry <= wide[data_width];
    end
  end

  // INr and DCr must keep carry intact
  carry_kept_on_inc_dec: assert property (
    @(posedge clock) disable iff (rst) carry_we |-> !(op inside {OP_INC, OP_DEC})
  );

endmodule

`default_nettype wire

//--- logic/cpu8008_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8008_core #(
  parameter int data_width = cpu8008_pkg::data_width,
  parameter int pc_width = cpu8008_pkg::pc_width
) (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    ready,
  input  logic [data_width-1:0]   data_in,
  output logic [data_width-1:0]   data_out,
  output logic                    sync,
  output cpu8008_pkg::state_t     state
);
  import cpu8008_pkg::*;

  cycle_t cycle;
  logic ends_at_t3;
  logic last_cycle;
  logic halt;
  bus_src_t bus_src;
  reg_idx_t reg_sel;
  logic reg_we;
  logic load_ir;
  logic load_tmp_a;
  logic load_tmp_b;
  logic load_out;
  logic pc_inc;
  logic pc_load_low;
  logic pc_load_high;
  cycle_type_t cycle_type;
  alu_op_t alu_op;
  logic carry_we;

  logic [data_width-1:0] bus;
  logic [data_width-1:0] ir;
  logic [data_width-1:0] tmp_a;
  logic [data_width-1:0] tmp_b;
  logic [data_width-1:0] reg_rdata;
  logic [data_width-1:0] acc;
  logic [data_width-1:0] alu_result;
  logic [data_width-1:0] pc_low;
  logic [data_width-1:0] pc_high;
  logic [data_width-1:0] pc_load_data;
  instr_u dec_instr;

  // internal bus, one source at a time
  always_comb begin
    case (bus_src)
      SRC_INPUT: bus = data_in;
      SRC_REG: bus = reg_rdata;
      SRC_ALU: bus = alu_result;
      SRC_PC_LOW: bus = pc_low;
      SRC_PC_HIGH: bus = pc_high;
      SRC_TMP_B: bus = tmp_b;
      SRC_ACC: bus = acc;
      default: bus = ir;
    endcase
  end

  // fetch T3 decodes the incoming byte before IR holds it
  assign dec_instr = load_ir ? data_in : ir;
  // jump target comes straight from the temporaries
  assign pc_load_data = pc_load_high ? tmp_a : tmp_b;
  assign sync = (state == T1);

  // data_out captured at the end of T1 and T2
  always_ff @(posedge clock) begin
    if (rst) begin
      ir <= '0;
      data_out <= '0;
    end else begin
      if (load_ir) begin
        ir <= bus;
      end
      if (load_out) begin
        data_out <= bus;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load_tmp_a) begin
      tmp_a <= bus;
    end
    if (load_tmp_b) begin
      tmp_b <= bus;
    end
  end

  cycle_sequencer cycle_sequencer_inst (
    .clock, .rst, .ready, .ends_at_t3, .last_cycle, .halt, .state, .cycle
  );

  instr_decoder instr_decoder_inst (
    .instr(dec_instr), .state, .cycle, .ends_at_t3, .last_cycle, .halt,
    .bus_src, .reg_sel, .reg_we, .load_ir, .load_tmp_a, .load_tmp_b, .load_out,
    .pc_inc, .pc_load_low, .pc_load_high, .cycle_type, .alu_op, .carry_we
  );

  // B temporary is always the second alu operand
  alu #(.data_width(data_width)) alu_inst (
    .clock, .rst, .acc, .operand(tmp_b), .op(alu_op), .carry_we, .result(alu_result)
  );

  reg_file #(.data_width(data_width)) reg_file_inst (
    .clock, .sel(reg_sel), .we(reg_we), .wdata(bus), .rdata(reg_rdata), .acc
  );

  program_counter #(.data_width(data_width), .pc_width(pc_width)) program_counter_inst (
    .clock, .rst, .inc(pc_inc), .load_low(pc_load_low), .load_high(pc_load_high),
    .load_data(pc_load_data), .cycle_type, .low_byte(pc_low), .high_byte(pc_high)
  );

endmodule

`default_nettype wire

//--- logic/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter #(
  parameter int data_width = cpu8008_pkg::data_width,
  parameter int pc_width = cpu8008_pkg::pc_width
) (
  input  logic                        clock,
  input  logic                        rst,
  input  logic                        inc,
  input  logic                        load_low,
  input  logic                        load_high,
  input  logic [data_width-1:0]       load_data,
  input  cpu8008_pkg::cycle_type_t    cycle_type,
  output logic [data_width-1:0]       low_byte,
  output logic [data_width-1:0]       high_byte
);

  logic [pc_width-1:0] pc;
  // upper address bits as they were before the T1 increment
  logic [pc_width-data_width-1:0] addr_high;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= '0;
      addr_high <= '0;
    end else begin
      // jump target arrives high byte first (T4), then low (T5)
      if (load_low) begin
        pc[data_width-1:0] <= load_data;
      end else if (load_high) begin
        pc[pc_width-1:data_width] <= load_data[pc_width-data_width-1:0];
      end else if (inc) begin
        pc <= pc + 1'b1;
        // keep T2 on the same page as the T1 byte
        addr_high <= pc[pc_width-1:data_width];
      end
    end
  end

  assign low_byte = pc[data_width-1:0];
  // cycle type rides on top of the address
  assign high_byte = {cycle_type, addr_high};

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int data_width = cpu8008_pkg::data_width
) (
  input  logic                    clock,
  input  cpu8008_pkg::reg_idx_t   sel,
  input  logic                    we,
  input  logic [data_width-1:0]   wdata,
  output logic [data_width-1:0]   rdata,
  output logic [data_width-1:0]   acc
);
  import cpu8008_pkg::*;

  // A, B, C, D, E, H, L
  localparam int num_regs = 7;

  logic [data_width-1:0] regs [num_regs];

  always_ff @(posedge clock) begin
    if (we) begin
      regs[sel] <= wdata;
    end
  end

  // index 7 would be memory, read back as zero
  assign rdata = (sel < num_regs) ? regs[sel] : '0;
  // accumulator always feeds the alu
  assign acc = regs[REG_A];

  // memory operand forms are not decoded, so no write may reach index 7
  no_memory_write: assert property (@(posedge clock) we |-> (sel < num_regs));

endmodule

`default_nettype wire

//--- tests/cpu8008_programs.svh
`ifndef CPU8008_PROGRAMS_SVH
`define CPU8008_PROGRAMS_SVH

localparam int num_programs = 3;
localparam int num_segments = 3;

// program bytes as hex pairs, one string per segment
string seg_text [num_programs][num_segments] = '{
  // LrI into B..L, moves to A, OUT each, then MOV B,L
  '{ {"0E11", "1622", "1E33", "2644", "2E55", "3666",
      "C151", "C251", "C351", "C451", "C551", "C651", "CEC151", "FF"}, "", "" },
  // register and immediate alu ops, ADC/SBB after carry from ADD and CMP
  '{ {"06F0", "0420", "0C05", "51", "0E20", "91", "51", "99", "51",
      "3CE0", "0C00", "51", "0610", "3C20", "1C01", "51",
      "04F5", "2407", "0C00", "51", "165A", "AA", "51", "B1", "51",
      "82", "89", "340C", "2C0F", "51", "FF"}, "", "" },
  // INr/DCr wrap, carry kept, two jumps across pages
  '{ {"06FF", "0401", "0EFF", "08", "C1", "51", "09", "C1", "51", "0C00", "51", "440021"},
     {"167E", "10", "C2", "51", "44103F"},
     {"11", "C2", "51", "FF"} }
};

// load address of each segment
localparam int seg_base [num_programs][num_segments] = '{
  '{0, 0, 0},
  '{0, 0, 0},
  '{0, 'h2100, 'h3F10}
};

// OUT bytes in order, as hex pairs
string out_text [num_programs] = '{
  "11223344556666",
  "16F6D5D60E035979F0",
  "00FF007F7E"
};

// address of the HLT opcode
localparam int halt_addr [num_programs] = '{27, 45, 'h3F13};

// instructions executed, sizes the watchdog
localparam int instr_count [num_programs] = '{22, 31, 21};

`endif

//--- tests/cpu8008_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8008_tb;
  import cpu8008_pkg::*;

  `include "cpu8008_programs.svh"

  logic clock;
  logic rst;
  logic ready;
  logic [7:0] data_in;
  logic [7:0] data_out;
  logic sync;
  state_t state;

  integer seed = 81;
  logic [7:0] mem [16384];
  logic [7:0] out_expected [$];
  bit running;
  bit halted;
  bit was_waiting;
  int next_addr;
  int halt_seen;
  int operands_left;
  cycle_type_t exp_type;
  logic [7:0] cur_op;
  logic [7:0] jmp_low;
  logic [7:0] addr_low;

  cpu8008_core cpu8008_core_inst (
    .clock, .rst, .ready, .data_in, .data_out, .sync, .state
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      fail_with("byte mismatch");
    end
  endtask

  task automatic check_state(input string name, input state_t expected, input state_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      fail_with("state mismatch");
    end
  endtask

  task automatic check_cycle_type(input string name, input cycle_type_t expected,
                                  input cycle_type_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      fail_with("cycle type mismatch");
    end
  endtask

  function automatic logic [3:0] hex_digit(input byte c);
    if (c >= "0" && c <= "9") begin
      return 4'(c - "0");
    end
    return 4'(c - "A" + 10);
  endfunction

  function automatic logic [7:0] hex_byte(input string s, input int i);
    return {hex_digit(s[i]), hex_digit(s[i + 1])};
  endfunction

  // number of operand bytes that follow the opcode
  function automatic int operand_count(input logic [7:0] op);
    if ((op & 8'hC7) == 8'h44) begin
      return 2;
    end
    if ((op & 8'hC7) == 8'h06 || (op & 8'hC7) == 8'h04) begin
      return 1;
    end
    return 0;
  endfunction

  function automatic bit opcode_is_out(input logic [7:0] op);
    return op[7:6] == 2'b01 && op[0] && op[5:4] != 2'b00;
  endfunction

  function automatic longint watchdog_ns();
    int states;
    states = 0;
    for (int p = 0; p < num_programs; p++) begin
      // 12 states each, four times over for READY stalls, plus reset
      states += instr_count[p] * 12 * 4 + 16;
    end
    return longint'(states) * 100;
  endfunction

  task automatic load_program(input int p);
    int base;
    for (int a = 0; a < 16384; a++) begin
      mem[a] = 8'(a ^ (a >> 6) ^ (a >> 11));
    end
    for (int s = 0; s < num_segments; s++) begin
      base = seg_base[p][s];
      for (int i = 0; i < seg_text[p][s].len() / 2; i++) begin
        mem[(base + i) & 16383] = hex_byte(seg_text[p][s], 2 * i);
      end
    end
    out_expected.delete();
    for (int i = 0; i < out_text[p].len() / 2; i++) begin
      out_expected.push_back(hex_byte(out_text[p], 2 * i));
    end
  endtask

  // address latch, memory reads, OUT capture and READY stalls
  always @(negedge clock) begin
    if (running) begin
      check_byte("sync", {7'b0, state == T1}, {7'b0, sync});
      // after T2 or WAIT the READY level picks T3 or another WAIT
      if (was_waiting) begin
        check_state("state", ready ? T3 : WAIT, state);
      end
      was_waiting = (state == T2 || state == WAIT);
      ready = 1'b1;
      if (state == T2) begin
        addr_low = data_out;
        ready = ($random(seed) & 3) != 0;
      end else if (state == WAIT) begin
        ready = ($random(seed) & 3) != 0;
      end else if (state == T3) begin
        check_cycle_type("cycle_type", exp_type, cycle_type_t'(data_out[7:6]));
        if (exp_type == PCC) begin
          // T1 byte is A and T2 byte is the OUT opcode
          check_byte("out_opcode", cur_op, data_out);
          if (out_expected.size() == 0) begin
            fail_with("OUT cycle seen with no OUT value left to expect");
          end
          check_byte("out_value", out_expected.pop_front(), addr_low);
          exp_type = PCI;
        end else begin
          check_byte("addr_low", next_addr[7:0], addr_low);
          check_byte("addr_high", {2'b0, next_addr[13:8]}, {2'b0, data_out[5:0]});
          data_in = mem[next_addr];
          if (exp_type == PCI) begin
            cur_op = data_in;
            operands_left = operand_count(cur_op);
            if (operands_left > 0) begin
              exp_type = PCR;
            end else if (opcode_is_out(cur_op)) begin
              exp_type = PCC;
            end else if (cur_op == 8'hFF || cur_op == 8'h00 || cur_op == 8'h01) begin
              halted = 1'b1;
              halt_seen = next_addr;
            end
            next_addr = (next_addr + 1) & 16383;
          end else begin
            operands_left--;
            next_addr = (next_addr + 1) & 16383;
            if (operand_count(cur_op) == 2 && operands_left == 1) begin
              jmp_low = data_in;
            end else if (operand_count(cur_op) == 2) begin
              next_addr = {data_in[5:0], jmp_low};
            end
            if (operands_left == 0) begin
              exp_type = PCI;
            end
          end
        end
      end
    end
  end

  initial begin
    #(watchdog_ns());
    $display("watchdog expired, the CPU never reached its halt");
    $display("STATUS: FAIL");
    $fatal(1);
  end

  initial begin
    rst = 1'b1;
    ready = 1'b1;
    data_in = 8'h00;
    running = 1'b0;
    was_waiting = 1'b0;
    for (int p = 0; p < num_programs; p++) begin
      load_program(p);
      exp_type = PCI;
      next_addr = 0;
      halted = 1'b0;
      was_waiting = 1'b0;
      rst = 1'b1;
      repeat (8) @(negedge clock);
      rst = 1'b0;
      running = 1'b1;
      while (state != STOPPED) begin
        @(negedge clock);
      end
      if (!halted || halt_seen != halt_addr[p]) begin
        fail_with($sformatf("program %0d halted at the wrong address %h", p, halt_seen));
      end
      if (out_expected.size() != 0) begin
        fail_with($sformatf("program %0d halted with OUT values missing", p));
      end
      // STOPPED holds with no new T1
      repeat (4) begin
        @(negedge clock);
        check_state("state", STOPPED, state);
      end
      running = 1'b0;
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
